// ==== Makefile ====
# Verilator build and run for the scope control front end

VERILATOR ?= verilator
TOP       ?= tb_scope_ctrl
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SHELL       := /bin/bash
.SHELLFLAGS := -o pipefail -c

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/cmd_dispatch.sv ====
// command dispatcher: decodes commands, holds acquisition settings and builds responses
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch (
   input  logic                              clk50,
   input  logic                              pllreset2,
   input  logic                              i_cmd_valid,
   input  cmd_pkg::cmd_bytes_t               i_cmd,
   input  logic [7:0]                        i_boardin,
   input  logic [cmd_pkg::NUM_OVERRANGE-1:0] i_overrange,
   input  logic                              i_spi_done,
   input  logic [15:0]                       i_spi_result,
   input  logic                              i_resp_done,
   output logic                              o_busy,
   output logic                              o_spi_start,
   output logic [2:0]                        o_spi_chip,
   output logic [3:0][7:0]                   o_spi_bytes,
   output logic [7:0]                        o_spi_count,
   output logic                              o_resp_valid,
   output cmd_pkg::resp_word_t               o_resp_data,
   output logic [1:0]                        o_spi_mode,
   output logic                              o_spi_reset_n,
   output cmd_pkg::thresh_t                  o_lower_thresh,
   output cmd_pkg::thresh_t                  o_upper_thresh,
   output logic [7:0]                        o_trigger_tot,
   output logic                              o_trigger_chan,
   output logic [4:0]                        o_downsample,
   output logic                              o_highres,
   output logic [7:0]                        o_downsample_merging,
   output logic [7:0]                        o_boardout,
   output logic                              o_fan_on,
   output logic                              o_rolling
);
   import cmd_pkg::*;

   localparam int OR_IDX_W = $clog2(NUM_OVERRANGE);

   logic [7:0]               boardin_sync;
   logic [NUM_OVERRANGE-1:0] overrange_sync;
   logic [31:0]              or_count [NUM_OVERRANGE];
   logic [7:0]               opcode;
   logic [7:0]               sub;
   thresh_t                  lower_calc;
   thresh_t                  upper_calc;
   resp_word_t               resp_next;
   logic                     known;

   assign opcode = i_cmd[0];
   assign sub    = i_cmd[1];

   // ((b1 -/+ b2 - 128) << 4) + 8, wraps to 12 bits
   assign lower_calc = ((12'(i_cmd[1]) - 12'(i_cmd[2]) - 12'd128) << 4) + 12'd8;
   assign upper_calc = ((12'(i_cmd[1]) + 12'(i_cmd[2]) - 12'd128) << 4) + 12'd8;

   // spi fields come straight from the held command
   assign o_spi_chip  = i_cmd[1][2:0];
   assign o_spi_bytes = i_cmd[5:2];
   assign o_spi_count = i_cmd[7];

   always_ff @(posedge clk50) begin
      boardin_sync   <= i_boardin;   // one stage into clk50
      overrange_sync <= i_overrange;
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         for (int k = 0; k < NUM_OVERRANGE; k++) or_count[k] <= '0;
      end else begin
         for (int k = 0; k < NUM_OVERRANGE; k++) begin
            if (overrange_sync[k]) or_count[k] <= or_count[k] + 32'd1;   // cycles high
         end
      end
   end

   // response word for the current command, old values where a setting changes
   always_comb begin
      resp_next = '0;
      known     = 1'b1;
      case (opcode)
         OP_STATUS: begin
            case (sub)
               8'd0:    resp_next = FW_VERSION;
               8'd1:    resp_next = {24'd0, boardin_sync};
               8'd2:    resp_next = or_count[i_cmd[2][OR_IDX_W-1:0]];
               8'd6:    resp_next = {31'd0, o_fan_on};
               8'd8:    resp_next = {31'd0, o_rolling};
               default: resp_next = '0;
            endcase
         end
         OP_SPI:        resp_next = '0;   // word comes from the sequencer later
         OP_SPI_MODE:   resp_next = {24'd0, i_cmd[1]};
         OP_TRIG_SET:   resp_next = 32'd8;
         OP_DOWNSAMPLE: resp_next = 32'd9;
         OP_BOARDOUT:   resp_next = {24'd0, o_boardout};
         OP_READ_REG: begin
            case (sub)
               8'd4:    resp_next = {24'd0, boardin_sync};
               8'd9:    resp_next = {24'd0, o_downsample_merging};
               8'd10:   resp_next = {27'd0, o_downsample};
               8'd11:   resp_next = {31'd0, o_highres};
               8'd12:   resp_next = {20'd0, o_upper_thresh};
               default: resp_next = '0;
            endcase
         end
         default: known = 1'b0;
      endcase
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_busy               <= 1'b0;
         o_spi_start          <= 1'b0;
         o_resp_valid         <= 1'b0;
         o_spi_mode           <= '0;
         o_spi_reset_n        <= 1'b1;
         o_lower_thresh       <= '0;
         o_upper_thresh       <= '0;
         o_trigger_tot        <= '0;
         o_trigger_chan       <= 1'b0;
         o_downsample         <= '0;
         o_highres            <= 1'b0;
         o_downsample_merging <= '0;
         o_boardout           <= '0;
         o_fan_on             <= 1'b0;
         o_rolling            <= 1'b0;
      end else begin
         o_spi_start   <= 1'b0;
         o_resp_valid  <= i_spi_done;   // spi answer one cycle after done
         o_spi_reset_n <= 1'b1;
         if (i_resp_done) o_busy <= 1'b0;
         if (i_cmd_valid) begin
            o_busy       <= known;   // unknown opcodes drop straight back to idle
            o_resp_valid <= known && (opcode != OP_SPI);
            o_spi_start  <= (opcode == OP_SPI);
            case (opcode)
               OP_STATUS: begin
                  if (sub == 8'd6) o_fan_on <= i_cmd[2][0];
                  if (sub == 8'd8) o_rolling <= i_cmd[2][0];
               end
               OP_SPI_MODE: begin
                  o_spi_mode    <= i_cmd[1][1:0];
                  o_spi_reset_n <= 1'b0;   // one cycle reset of the spi master
               end
               OP_TRIG_SET: begin
                  o_lower_thresh <= lower_calc;
                  o_upper_thresh <= upper_calc;
                  o_trigger_tot  <= i_cmd[5];
                  o_trigger_chan <= i_cmd[6][0];
               end
               OP_DOWNSAMPLE: begin
                  o_downsample         <= i_cmd[1][4:0];
                  o_highres            <= i_cmd[2][0];
                  o_downsample_merging <= i_cmd[3];
               end
               OP_BOARDOUT: o_boardout[i_cmd[1][2:0]] <= i_cmd[2][0];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk50) begin
      if (i_spi_done) begin
         o_resp_data <= {16'd0, i_spi_result};
      end else if (i_cmd_valid) begin
         o_resp_data <= resp_next;
      end
   end

endmodule

`default_nettype wire

// ==== hw/cmd_pkg.sv ====
// command front end definitions: opcodes, command and response types, firmware version
`default_nettype none

package cmd_pkg;

   localparam int CMD_BYTES     = 8;    // bytes per host command
   localparam int NUM_OVERRANGE = 4;    // ORA0, ORA1, ORB0, ORB1

   typedef logic [CMD_BYTES-1:0][7:0] cmd_bytes_t;   // byte 0 is the opcode
   typedef logic [31:0]               resp_word_t;
   typedef logic signed [11:0]        thresh_t;

   localparam resp_word_t FW_VERSION = 32'd29;

   // opcodes in byte 0
   localparam logic [7:0] OP_STATUS     = 8'd2;
   localparam logic [7:0] OP_SPI        = 8'd3;
   localparam logic [7:0] OP_SPI_MODE   = 8'd4;
   localparam logic [7:0] OP_TRIG_SET   = 8'd8;
   localparam logic [7:0] OP_DOWNSAMPLE = 8'd9;
   localparam logic [7:0] OP_BOARDOUT   = 8'd10;
   localparam logic [7:0] OP_READ_REG   = 8'd14;

endpackage

`default_nettype wire

// ==== hw/scope_ctrl_top.sv ====
// scope control top: usb command receiver, dispatcher, spi sequencer and response sender
`timescale 1ns/1ps
`default_nettype none

module scope_ctrl_top #(
   parameter int CS_SETUP_CYCLES = 10,
   parameter int CS_HOLD_CYCLES  = 35
) (
   input  logic                              clk50,
   input  logic                              pllreset2,
   input  logic                              i_in_tvalid,
   input  logic [7:0]                        i_in_tdata,
   output logic                              o_in_tready,
   output logic                              o_out_tvalid,
   output cmd_pkg::resp_word_t               o_out_tdata,
   output logic [3:0]                        o_out_tkeep,
   output logic                              o_out_tlast,
   input  logic                              i_out_tready,
   output logic [7:0]                        o_spi_tx,
   output logic                              o_spi_tx_dv,
   input  logic                              i_spi_tx_ready,
   input  logic [7:0]                        i_spi_rx,
   input  logic                              i_spi_rx_dv,
   output logic [7:0]                        o_spi_cs,
   output logic [2:0]                        o_spi_miso_sel,
   input  logic [7:0]                        i_boardin,
   input  logic [cmd_pkg::NUM_OVERRANGE-1:0] i_overrange,
   output logic [1:0]                        o_spi_mode,
   output logic                              o_spi_reset_n,
   output cmd_pkg::thresh_t                  o_lower_thresh,
   output cmd_pkg::thresh_t                  o_upper_thresh,
   output logic [7:0]                        o_trigger_tot,
   output logic                              o_trigger_chan,
   output logic [4:0]                        o_downsample,
   output logic                              o_highres,
   output logic [7:0]                        o_downsample_merging,
   output logic [7:0]                        o_boardout,
   output logic                              o_fan_on,
   output logic                              o_rolling
);
   import cmd_pkg::*;

   logic            busy;
   logic            cmd_valid;
   cmd_bytes_t      cmd;
   logic            spi_start;
   logic [2:0]      spi_chip;
   logic [3:0][7:0] spi_bytes;
   logic [7:0]      spi_count;
   logic            spi_done;
   logic [15:0]     spi_result;
   logic            resp_valid;
   resp_word_t      resp_data;
   logic            resp_done;

   usb_cmd_rx u_rx (
      .clk50       (clk50),
      .pllreset2   (pllreset2),
      .i_in_tvalid (i_in_tvalid),
      .i_in_tdata  (i_in_tdata),
      .i_busy      (busy),
      .o_in_tready (o_in_tready),
      .o_cmd_valid (cmd_valid),
      .o_cmd       (cmd)
   );

   cmd_dispatch u_dispatch (
      .clk50                (clk50),
      .pllreset2            (pllreset2),
      .i_cmd_valid          (cmd_valid),
      .i_cmd                (cmd),
      .i_boardin            (i_boardin),
      .i_overrange          (i_overrange),
      .i_spi_done           (spi_done),
      .i_spi_result         (spi_result),
      .i_resp_done          (resp_done),
      .o_busy               (busy),
      .o_spi_start          (spi_start),
      .o_spi_chip           (spi_chip),
      .o_spi_bytes          (spi_bytes),
      .o_spi_count          (spi_count),
      .o_resp_valid         (resp_valid),
      .o_resp_data          (resp_data),
      .o_spi_mode           (o_spi_mode),
      .o_spi_reset_n        (o_spi_reset_n),
      .o_lower_thresh       (o_lower_thresh),
      .o_upper_thresh       (o_upper_thresh),
      .o_trigger_tot        (o_trigger_tot),
      .o_trigger_chan       (o_trigger_chan),
      .o_downsample         (o_downsample),
      .o_highres            (o_highres),
      .o_downsample_merging (o_downsample_merging),
      .o_boardout           (o_boardout),
      .o_fan_on             (o_fan_on),
      .o_rolling            (o_rolling)
   );

   spi_sequencer #(
      .CS_SETUP_CYCLES (CS_SETUP_CYCLES),
      .CS_HOLD_CYCLES  (CS_HOLD_CYCLES)
   ) u_spi (
      .clk50          (clk50),
      .pllreset2      (pllreset2),
      .i_start        (spi_start),
      .i_chip         (spi_chip),
      .i_bytes        (spi_bytes),
      .i_count        (spi_count),
      .i_spi_tx_ready (i_spi_tx_ready),
      .i_spi_rx       (i_spi_rx),
      .i_spi_rx_dv    (i_spi_rx_dv),
      .o_done         (spi_done),
      .o_result       (spi_result),
      .o_spi_tx       (o_spi_tx),
      .o_spi_tx_dv    (o_spi_tx_dv),
      .o_spi_cs       (o_spi_cs),
      .o_spi_miso_sel (o_spi_miso_sel)
   );

   usb_resp_tx u_tx (
      .clk50        (clk50),
      .pllreset2    (pllreset2),
      .i_resp_valid (resp_valid),
      .i_resp_data  (resp_data),
      .i_out_tready (i_out_tready),
      .o_resp_done  (resp_done),
      .o_out_tvalid (o_out_tvalid),
      .o_out_tdata  (o_out_tdata),
      .o_out_tkeep  (o_out_tkeep),
      .o_out_tlast  (o_out_tlast)
   );

endmodule

`default_nettype wire

// ==== hw/spi_sequencer.sv ====
// spi sequencer: frames a 2 to 4 byte exchange with one chip select
`timescale 1ns/1ps
`default_nettype none

module spi_sequencer #(
   parameter int CS_SETUP_CYCLES = 10,
   parameter int CS_HOLD_CYCLES  = 35
) (
   input  logic            clk50,
   input  logic            pllreset2,
   input  logic            i_start,
   input  logic [2:0]      i_chip,
   input  logic [3:0][7:0] i_bytes,
   input  logic [7:0]      i_count,
   input  logic            i_spi_tx_ready,
   input  logic [7:0]      i_spi_rx,
   input  logic            i_spi_rx_dv,
   output logic            o_done,
   output logic [15:0]     o_result,
   output logic [7:0]      o_spi_tx,
   output logic            o_spi_tx_dv,
   output logic [7:0]      o_spi_cs,
   output logic [2:0]      o_spi_miso_sel
);

   localparam int WAIT_MAX = (CS_SETUP_CYCLES > CS_HOLD_CYCLES) ? CS_SETUP_CYCLES
                                                                : CS_HOLD_CYCLES;
   localparam int WAIT_W   = $clog2(WAIT_MAX + 1);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SETUP,
      ST_SEND,
      ST_WAIT_RX,
      ST_HOLD
   } state_t;

   state_t            state;
   logic [WAIT_W-1:0] wait_cnt;
   logic [1:0]        byte_idx;
   logic [1:0]        last_idx;
   logic [3:0][7:0]   tx_bytes;
   logic              take_start;
   logic              rx_hit;

   assign take_start = i_start && (state == ST_IDLE);
   assign rx_hit     = i_spi_rx_dv && (state == ST_WAIT_RX);

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state          <= ST_IDLE;
         wait_cnt       <= '0;
         byte_idx       <= '0;
         last_idx       <= 2'd1;
         o_done         <= 1'b0;
         o_spi_tx_dv    <= 1'b0;
         o_spi_cs       <= '1;
         o_spi_miso_sel <= '0;
      end else begin
         o_done      <= 1'b0;
         o_spi_tx_dv <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (i_start) begin
                  o_spi_cs[i_chip] <= 1'b0;   // select requested chip
                  o_spi_miso_sel   <= i_chip;
                  wait_cnt         <= '0;
                  byte_idx         <= '0;
                  if (i_count < 8'd2)      last_idx <= 2'd1;   // at least 2 bytes
                  else if (i_count > 8'd4) last_idx <= 2'd3;   // at most 4
                  else                     last_idx <= i_count[1:0] - 2'd1;
                  state <= ST_SETUP;
               end
            end
            ST_SETUP: begin
               if (wait_cnt == WAIT_W'(CS_SETUP_CYCLES - 1)) state <= ST_SEND;
               else wait_cnt <= wait_cnt + 1'b1;
            end
            ST_SEND: begin
               if (i_spi_tx_ready) begin
                  o_spi_tx_dv <= 1'b1;
                  state       <= ST_WAIT_RX;
               end
            end
            ST_WAIT_RX: begin
               if (i_spi_rx_dv) begin
                  if (byte_idx == last_idx) begin
                     wait_cnt <= '0;
                     state    <= ST_HOLD;
                  end else begin
                     byte_idx <= byte_idx + 2'd1;
                     state    <= ST_SEND;
                  end
               end
            end
            ST_HOLD: begin
               if (wait_cnt == WAIT_W'(CS_HOLD_CYCLES - 1)) begin
                  o_spi_cs <= '1;   // deselect and report together
                  o_done   <= 1'b1;
                  state    <= ST_IDLE;
               end else begin
                  wait_cnt <= wait_cnt + 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // transmit bytes and received data
   always_ff @(posedge clk50) begin
      if (take_start) tx_bytes <= i_bytes;
      if (state == ST_SEND && i_spi_tx_ready) o_spi_tx <= tx_bytes[byte_idx];
      if (rx_hit && byte_idx == 2'd0) o_result[15:8] <= i_spi_rx;   // first byte back
      if (rx_hit && byte_idx == last_idx) o_result[7:0] <= i_spi_rx;   // last byte back
   end

endmodule

`default_nettype wire

// ==== hw/usb_cmd_rx.sv ====
// usb command receiver: gathers eight stream bytes into one command and flags it
`timescale 1ns/1ps
`default_nettype none

module usb_cmd_rx (
   input  logic                clk50,
   input  logic                pllreset2,
   input  logic                i_in_tvalid,
   input  logic [7:0]          i_in_tdata,
   input  logic                i_busy,
   output logic                o_in_tready,
   output logic                o_cmd_valid,
   output cmd_pkg::cmd_bytes_t o_cmd
);
   import cmd_pkg::*;

   localparam int CNT_W = $clog2(CMD_BYTES);

   logic [CNT_W-1:0] byte_cnt;
   logic             accept;

   assign o_in_tready = !o_cmd_valid && !i_busy;   // hold off while a command is in flight
   assign accept      = i_in_tvalid && o_in_tready;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         byte_cnt    <= '0;
         o_cmd_valid <= 1'b0;
      end else begin
         o_cmd_valid <= 1'b0;
         if (accept) begin
            if (byte_cnt == CNT_W'(CMD_BYTES - 1)) begin
               byte_cnt    <= '0;
               o_cmd_valid <= 1'b1;   // whole command in
            end else begin
               byte_cnt <= byte_cnt + 1'b1;
            end
         end
      end
   end

   // command buffer, stays put until the next command starts
   always_ff @(posedge clk50) begin
      if (accept) begin
         o_cmd[byte_cnt] <= i_in_tdata;
      end
   end

endmodule

`default_nettype wire

// ==== hw/usb_resp_tx.sv ====
// usb response transmitter: holds one response word on the output stream until taken
`timescale 1ns/1ps
`default_nettype none

module usb_resp_tx (
   input  logic                clk50,
   input  logic                pllreset2,
   input  logic                i_resp_valid,
   input  cmd_pkg::resp_word_t i_resp_data,
   input  logic                i_out_tready,
   output logic                o_resp_done,
   output logic                o_out_tvalid,
   output cmd_pkg::resp_word_t o_out_tdata,
   output logic [3:0]          o_out_tkeep,
   output logic                o_out_tlast
);

   assign o_resp_done = o_out_tvalid && i_out_tready;   // host takes the word
   assign o_out_tkeep = {4{o_out_tvalid}};              // always a full 4-byte beat
   assign o_out_tlast = o_out_tvalid;                   // single beat per response

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_out_tvalid <= 1'b0;
      end else if (i_resp_valid) begin
         o_out_tvalid <= 1'b1;
      end else if (o_resp_done) begin
         o_out_tvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk50) begin
      if (i_resp_valid) begin
         o_out_tdata <= i_resp_data;
      end
   end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/cmd_pkg.sv
hw/usb_cmd_rx.sv
hw/cmd_dispatch.sv
hw/spi_sequencer.sv
hw/usb_resp_tx.sv
hw/scope_ctrl_top.sv
tb/scope_ctrl_sva.sv
tb/tb_scope_ctrl.sv

// ==== tb/scope_ctrl_sva.sv ====
// protocol checker for the output stream and spi chip selects, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module scope_ctrl_sva (
   input logic                clk50,
   input logic                pllreset2,
   input logic                i_out_tready,
   input logic                o_out_tvalid,
   input cmd_pkg::resp_word_t o_out_tdata,
   input logic [3:0]          o_out_tkeep,
   input logic                o_out_tlast,
   input logic                o_in_tready,
   input logic [7:0]          o_spi_cs
);

   // word must sit still until the host takes it
   a_out_hold: assert property (@(posedge clk50) disable iff (pllreset2)
      (o_out_tvalid && !i_out_tready) |=> (o_out_tvalid && $stable(o_out_tdata)))
      else $error("output word changed or dropped before the host took it");

   a_keep_last: assert property (@(posedge clk50) disable iff (pllreset2)
      (o_out_tkeep == {4{o_out_tvalid}}) && (o_out_tlast == o_out_tvalid))
      else $error("keep or last does not follow valid");

   a_one_cs: assert property (@(posedge clk50) disable iff (pllreset2)
      $onehot0(~o_spi_cs))   // active low selects
      else $error("more than one chip select low");

   a_no_rx: assert property (@(posedge clk50) disable iff (pllreset2)
      o_out_tvalid |-> !o_in_tready)
      else $error("input stream ready while a response is pending");

endmodule

bind scope_ctrl_top scope_ctrl_sva sva0 (
   .clk50        (clk50),
   .pllreset2    (pllreset2),
   .i_out_tready (i_out_tready),
   .o_out_tvalid (o_out_tvalid),
   .o_out_tdata  (o_out_tdata),
   .o_out_tkeep  (o_out_tkeep),
   .o_out_tlast  (o_out_tlast),
   .o_in_tready  (o_in_tready),
   .o_spi_cs     (o_spi_cs)
);

`default_nettype wire

// ==== tb/tb_scope_ctrl.sv ====
// testbench for the scope control front end with random commands checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_scope_ctrl;
   import cmd_pkg::*;

   localparam int     NUM_CMDS    = 300;
   localparam int     CS_SETUP    = 10;
   localparam int     CS_HOLD     = 35;
   localparam int     RESP_CYCLES = 2000;   // budget per command
   localparam longint WATCHDOG_NS = longint'(NUM_CMDS) * RESP_CYCLES * 20;
   localparam logic [5:0][7:0] STATUS_SUBS = {8'd0, 8'd1, 8'd2, 8'd6, 8'd8, 8'd5};
   localparam logic [5:0][7:0] REG_SUBS    = {8'd4, 8'd9, 8'd10, 8'd11, 8'd12, 8'd7};
   localparam logic [5:0][7:0] BAD_OPS     = {8'd0, 8'd1, 8'd5, 8'd7, 8'd15, 8'd200};

   logic clk50, pllreset2;
   logic i_in_tvalid, o_in_tready, o_out_tvalid, o_out_tlast, i_out_tready;
   logic [7:0] i_in_tdata;
   resp_word_t o_out_tdata;
   logic [3:0] o_out_tkeep;
   logic [7:0] o_spi_tx, o_spi_cs, i_spi_rx, i_boardin;
   logic o_spi_tx_dv, i_spi_tx_ready, i_spi_rx_dv;
   logic [2:0] o_spi_miso_sel;
   logic [NUM_OVERRANGE-1:0] i_overrange;
   logic [1:0] o_spi_mode;
   logic o_spi_reset_n, o_trigger_chan, o_highres, o_fan_on, o_rolling;
   thresh_t o_lower_thresh, o_upper_thresh;
   logic [7:0] o_trigger_tot, o_downsample_merging, o_boardout;
   logic [4:0] o_downsample;

   int seed, bp_seed, spi_seed;
   int errors, checks, seen_resets;
   resp_word_t resp_q [$];
   logic [7:0] spi_sent [$];
   logic [7:0] spi_last_tx;
   logic [2:0] spi_chip_exp;

   // reference model of the settings
   logic [1:0] m_spi_mode;
   thresh_t m_lower, m_upper;
   logic [7:0] m_tot, m_merge, m_boardout;
   logic [4:0] m_down;
   logic m_chan, m_highres, m_fan, m_rolling;
   logic [31:0] m_or [NUM_OVERRANGE];
   int m_resets;

   scope_ctrl_top #(
      .CS_SETUP_CYCLES (CS_SETUP),
      .CS_HOLD_CYCLES  (CS_HOLD)
   ) dut0 (.*);

   function automatic int unsigned rand_below(inout int s, input int unsigned n);
      int r;
      r = $random(s);
      return $unsigned(r) % n;
   endfunction

   function automatic logic [7:0] rand_byte();
      return 8'(rand_below(seed, 256));
   endfunction

   task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Fail %0t: %s, got %08h, expected %08h", $time, what, got, exp);
      end
   endtask

   initial begin
      clk50 = 1'b0;
      forever #10 clk50 = ~clk50;
   end

   always @(posedge clk50) begin   // overrange high cycles seen by the board
      if (!pllreset2) begin
         for (int k = 0; k < NUM_OVERRANGE; k++) begin
            if (i_overrange[k]) m_or[k] = m_or[k] + 32'd1;
         end
      end
   end

   always @(posedge clk50) begin
      if (!pllreset2 && !o_spi_reset_n) seen_resets++;
   end

   // host side of the output stream with random back-pressure
   always @(posedge clk50) begin
      if (!pllreset2 && o_out_tvalid && i_out_tready) begin
         resp_q.push_back(o_out_tdata);
         check_val("keep and last on response", {27'd0, o_out_tkeep, o_out_tlast}, 32'h1f);
      end
      #1;
      i_out_tready = (rand_below(bp_seed, 4) != 0);
   end

   // spi partner echoes each byte xor 5a after a random delay
   always @(posedge clk50) begin
      if (!pllreset2 && o_spi_tx_dv) begin
         spi_sent.push_back(o_spi_tx);
         spi_last_tx = o_spi_tx;
         check_val("chip selects in transfer", 32'(o_spi_cs),
                   {24'd0, ~(8'h01 << spi_chip_exp)});
         check_val("miso select", 32'(o_spi_miso_sel), 32'(spi_chip_exp));
         #1;
         i_spi_tx_ready = 1'b0;
         repeat (int'(1 + rand_below(spi_seed, 8))) @(posedge clk50);
         #1;
         i_spi_rx_dv    = 1'b1;
         i_spi_rx       = spi_last_tx ^ 8'h5a;
         i_spi_tx_ready = 1'b1;
         @(posedge clk50);
         #1;
         i_spi_rx_dv = 1'b0;
      end
   end

   task automatic idle_phase();   // board inputs only change between commands
      int k;
      @(posedge clk50);
      #1;
      i_boardin = rand_byte();
      k = int'(rand_below(seed, 6));
      repeat (k) begin
         i_overrange = NUM_OVERRANGE'(rand_below(seed, 16));
         @(posedge clk50);
         #1;
      end
      i_overrange = '0;
      repeat (2) @(posedge clk50);   // let the sync stage and counters settle
      #1;
   endtask

   task automatic make_cmd(output cmd_bytes_t c);
      int kind;
      for (int i = 0; i < CMD_BYTES; i++) c[i] = rand_byte();
      kind = int'(rand_below(seed, 10));
      case (kind)
         0, 1: begin
            c[0] = OP_STATUS;
            c[1] = STATUS_SUBS[3'(rand_below(seed, 6))];
         end
         2: begin
            c[0] = OP_SPI;
            c[7] = 8'(2 + rand_below(seed, 3));
         end
         3: c[0] = OP_SPI_MODE;
         4: c[0] = OP_TRIG_SET;
         5: c[0] = OP_DOWNSAMPLE;
         6: c[0] = OP_BOARDOUT;
         7, 8: begin
            c[0] = OP_READ_REG;
            c[1] = REG_SUBS[3'(rand_below(seed, 6))];
         end
         default: c[0] = BAD_OPS[3'(rand_below(seed, 6))];
      endcase
   endtask

   // response predicted from the model state before the model update
   task automatic predict(input cmd_bytes_t c, output resp_word_t exp, output logic has);
      int lo;
      int hi;
      exp = '0;
      has = 1'b1;
      case (c[0])
         OP_STATUS: begin
            case (c[1])
               8'd0: exp = FW_VERSION;
               8'd1: exp = {24'd0, i_boardin};
               8'd2: exp = m_or[c[2][1:0]];
               8'd6: begin
                  exp   = {31'd0, m_fan};
                  m_fan = c[2][0];
               end
               8'd8: begin
                  exp       = {31'd0, m_rolling};
                  m_rolling = c[2][0];
               end
               default: exp = '0;
            endcase
         end
         OP_SPI: exp = {16'd0, c[2] ^ 8'h5a, c[1 + int'(c[7])] ^ 8'h5a};   // first and last echo
         OP_SPI_MODE: begin
            exp        = {24'd0, c[1]};
            m_spi_mode = c[1][1:0];
            m_resets++;
         end
         OP_TRIG_SET: begin
            lo      = (int'(c[1]) - int'(c[2]) - 128) * 16 + 8;
            hi      = (int'(c[1]) + int'(c[2]) - 128) * 16 + 8;
            m_lower = lo[11:0];
            m_upper = hi[11:0];
            m_tot   = c[5];
            m_chan  = c[6][0];
            exp     = 32'd8;
         end
         OP_DOWNSAMPLE: begin
            m_down    = c[1][4:0];
            m_highres = c[2][0];
            m_merge   = c[3];
            exp       = 32'd9;
         end
         OP_BOARDOUT: begin
            exp                     = {24'd0, m_boardout};
            m_boardout[c[1][2:0]] = c[2][0];
         end
         OP_READ_REG: begin
            case (c[1])
               8'd4:    exp = {24'd0, i_boardin};
               8'd9:    exp = {24'd0, m_merge};
               8'd10:   exp = {27'd0, m_down};
               8'd11:   exp = {31'd0, m_highres};
               8'd12:   exp = {20'd0, m_upper};
               default: exp = '0;
            endcase
         end
         default: has = 1'b0;   // unknown opcode gets no response
      endcase
   endtask

   task automatic send_cmd(input cmd_bytes_t c);
      @(posedge clk50);
      #1;
      for (int i = 0; i < CMD_BYTES; i++) begin
         i_in_tvalid = 1'b1;
         i_in_tdata  = c[i];
         @(posedge clk50);
         while (!o_in_tready) @(posedge clk50);
         #1;
      end
      i_in_tvalid = 1'b0;
      i_in_tdata  = '0;
   endtask

   task automatic wait_resp(input int n, input resp_word_t exp);
      int t;
      resp_word_t got;
      t = 0;
      while (resp_q.size() == 0 && t < RESP_CYCLES) begin
         @(negedge clk50);
         t++;
      end
      if (resp_q.size() == 0) begin
         errors++;
         $display("Timeout: command %0d got no response within %0d cycles", n, RESP_CYCLES);
      end else begin
         got = resp_q.pop_front();
         check_val($sformatf("response to command %0d", n), got, exp);
      end
   endtask

   task automatic check_settings();
      check_val("spi mode", 32'(o_spi_mode), 32'(m_spi_mode));
      check_val("lower threshold", 32'(o_lower_thresh), 32'(m_lower));
      check_val("upper threshold", 32'(o_upper_thresh), 32'(m_upper));
      check_val("time over threshold", 32'(o_trigger_tot), 32'(m_tot));
      check_val("trigger channel", 32'(o_trigger_chan), 32'(m_chan));
      check_val("downsample", 32'(o_downsample), 32'(m_down));
      check_val("highres", 32'(o_highres), 32'(m_highres));
      check_val("merging", 32'(o_downsample_merging), 32'(m_merge));
      check_val("boardout", 32'(o_boardout), 32'(m_boardout));
      check_val("fan", 32'(o_fan_on), 32'(m_fan));
      check_val("rolling", 32'(o_rolling), 32'(m_rolling));
      check_val("spi reset pulses", 32'(seen_resets), 32'(m_resets));
      check_val("chip selects idle", 32'(o_spi_cs), 32'hff);
   endtask

   task automatic check_spi(input cmd_bytes_t c);
      int cnt;
      cnt = (c[0] == OP_SPI) ? int'(c[7]) : 0;
      check_val("spi byte count", 32'(spi_sent.size()), 32'(cnt));
      for (int i = 0; i < spi_sent.size() && i < cnt; i++) begin
         check_val($sformatf("spi byte %0d", i), 32'(spi_sent[i]), 32'(c[2 + i]));
      end
      spi_sent.delete();
   endtask

   task automatic check_no_resp(input int n);
      repeat (20) @(negedge clk50);
      check_val($sformatf("responses to unknown command %0d", n), 32'(resp_q.size()), 32'd0);
      check_val("in_tready after unknown command", 32'(o_in_tready), 32'd1);
      resp_q.delete();
   endtask

   initial begin
      cmd_bytes_t c;
      resp_word_t exp;
      logic has;
      seed = 32'hc1708274;
      bp_seed = seed + 1;
      spi_seed = seed + 2;
      errors = 0;
      checks = 0;
      seen_resets = 0;
      m_resets = 0;
      {m_spi_mode, m_lower, m_upper, m_tot, m_chan} = '0;
      {m_down, m_highres, m_merge, m_boardout, m_fan, m_rolling} = '0;
      for (int k = 0; k < NUM_OVERRANGE; k++) m_or[k] = '0;
      spi_chip_exp = '0;
      pllreset2 = 1'b1;
      i_in_tvalid = 1'b0;
      i_in_tdata = '0;
      i_out_tready = 1'b1;
      i_spi_tx_ready = 1'b1;
      i_spi_rx = '0;
      i_spi_rx_dv = 1'b0;
      i_boardin = '0;
      i_overrange = '0;
      repeat (10) @(posedge clk50);
      #1 pllreset2 = 1'b0;
      @(negedge clk50);
      check_val("in_tready after reset", 32'(o_in_tready), 32'd1);
      check_val("out_tvalid after reset", 32'(o_out_tvalid), 32'd0);
      check_val("chip selects after reset", 32'(o_spi_cs), 32'hff);
      for (int n = 0; n < NUM_CMDS; n++) begin
         idle_phase();
         make_cmd(c);
         predict(c, exp, has);
         spi_chip_exp = c[1][2:0];
         send_cmd(c);
         if (has) begin
            wait_resp(n, exp);
            check_settings();
            check_spi(c);
         end else begin
            check_no_resp(n);
         end
      end
      repeat (20) @(negedge clk50);
      check_val("extra responses at end", 32'(resp_q.size()), 32'd0);
      $display("errors: %0d, checks: %0d, commands: %0d", errors, checks, NUM_CMDS);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire
